/* design/video_pkg.sv */
// shared definitions for the colour output stage
// raster timing sizes, palette geometry, width typedefs and the sync bundle
`default_nettype none

package video_pkg;

    // raster geometry, counted in pixels and lines
    localparam int CLK_PER_PIXEL = 4;           // clk cycles per pixel period
    localparam int H_ACTIVE = 32;               // visible pixels per line
    localparam int H_TOTAL = 40;                // all pixels per line, blanking included
    localparam int V_ACTIVE = 8;                // visible lines per frame
    localparam int V_TOTAL = 12;                // all lines per frame

    // palette RAM holds a low byte and a high byte per colour index
    localparam int PAL_AW = 10;                 // byte address width, 1024 bytes in all

    localparam logic [3:0] TRANSPARENT_NIBBLE = 4'hf;  // sprite code that shows the layer below

    typedef logic [8:0] layer_pixel_t;          // colour index coming from a layer
    typedef logic [PAL_AW-1:0] pal_addr_t;      // top bit picks the high byte half
    typedef logic [7:0] pal_byte_t;             // one palette byte
    typedef logic [4:0] colour_t;               // one 5-bit RGB channel
    typedef logic [5:0] hcount_t;               // beam column, 0 to H_TOTAL-1
    typedef logic [3:0] vcount_t;               // beam line, 0 to V_TOTAL-1

    // everything the raster generator hands to the rest of the chip
    typedef struct packed {
        logic pxl_cen;                          // one clk per pixel period
        logic hblank;                           // column outside the visible area
        logic vblank;                           // line outside the visible area
        hcount_t hcount;                        // current column
        vcount_t vcount;                        // current line
    } video_sync_t;

endpackage

`default_nettype wire

/* design/raster_timing.sv */
// raster timing generator
// pixel clock enable divider, beam counters and registered blanking flags
`timescale 1ns/1ps
`default_nettype none

module raster_timing
    import video_pkg::*;
(
    input wire logic clk,
    input wire logic reset,
    output video_sync_t sync                    // enable, blanking and beam position
);

    localparam logic [1:0] DIV_LAST = 2'(CLK_PER_PIXEL - 1);

    logic [1:0] div;                            // clk count inside one pixel period
    logic h_wrap;                               // last column of the line is on the beam
    hcount_t h_next;
    vcount_t v_next;

    always_comb begin
        h_wrap = sync.hcount == hcount_t'(H_TOTAL - 1);
        h_next = h_wrap ? '0 : sync.hcount + 1'b1;
        v_next = (sync.vcount == vcount_t'(V_TOTAL - 1)) ? '0 : sync.vcount + 1'b1;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            div <= '0;
            sync <= '0;                         // counters at the top left, no blanking
        end else begin
            div <= (div == DIV_LAST) ? '0 : div + 1'b1;
            sync.pxl_cen <= div == DIV_LAST;    // high on the fourth clk and every fourth after

            // the beam moves at the end of each pixel period
            if (sync.pxl_cen) begin
                sync.hcount <= h_next;
                sync.hblank <= h_next >= hcount_t'(H_ACTIVE);  // flag follows the new column
                if (h_wrap) begin
                    sync.vcount <= v_next;      // next line starts with column zero
                    sync.vblank <= v_next >= vcount_t'(V_ACTIVE);
                end
            end
        end
    end

endmodule

`default_nettype wire

/* design/palette_ram.sv */
// palette RAM, 1024 bytes with two synchronous ports on one clock
// port A reads and writes, port B only reads
`timescale 1ns/1ps
`default_nettype none

module palette_ram
    import video_pkg::*;
(
    input wire logic clk,
    input wire pal_addr_t a_addr,               // CPU side
    input wire logic a_we,
    input wire pal_byte_t a_wdata,
    output pal_byte_t a_rdata,
    input wire pal_addr_t b_addr,               // video side
    output pal_byte_t b_rdata
);

    pal_byte_t mem [0:(1 << PAL_AW) - 1];

    always_ff @(posedge clk) begin
        if (a_we) begin
            mem[a_addr] <= a_wdata;
        end
        a_rdata <= mem[a_addr];                 // old byte comes back on a write cycle
    end

    // a collision with a port A write also reads the old byte
    always_ff @(posedge clk) begin
        b_rdata <= mem[b_addr];
    end

endmodule

`default_nettype wire

/* design/palette_apb.sv */
// APB slave for the palette RAM
// writes finish in the first access cycle, reads wait one cycle for the RAM
`timescale 1ns/1ps
`default_nettype none

module palette_apb
    import video_pkg::*;
(
    input wire logic clk,
    input wire logic reset,
    input wire logic psel,
    input wire logic penable,
    input wire logic pwrite,
    input wire pal_addr_t paddr,
    input wire pal_byte_t pwdata,
    output pal_byte_t prdata,
    output logic pready,
    output pal_addr_t ram_addr,                 // to palette port A
    output logic ram_we,
    output pal_byte_t ram_wdata,
    input wire pal_byte_t ram_rdata
);

    typedef enum logic [1:0] {
        IDLE,                                   // waiting for a setup cycle
        READ_WAIT,                              // first access cycle of a read, RAM busy
        DONE                                    // completing access cycle, pready high
    } apb_state_t;

    apb_state_t state;
    apb_state_t state_next;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: if (psel && !penable) state_next = pwrite ? DONE : READ_WAIT;
            READ_WAIT: state_next = (psel && penable) ? DONE : IDLE;  // an aborted read goes back
            DONE: state_next = IDLE;            // next setup cycle may follow at once
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) state <= IDLE;
        else state <= state_next;
    end

    assign pready = state == DONE;
    assign ram_we = pready && psel && penable && pwrite;  // one write per transfer
    assign ram_addr = paddr;                    // the RAM reads every cycle, the FSM picks when
    assign ram_wdata = pwdata;
    assign prdata = ram_rdata;                  // valid in DONE after a READ_WAIT cycle

endmodule

`default_nettype wire

/* design/colour_mixer.sv */
// colour mixer
// sprite over scroll priority, two-byte palette fetch, RGB assembly and blanking
`timescale 1ns/1ps
`default_nettype none

module colour_mixer
    import video_pkg::*;
(
    input wire logic clk,
    input wire logic reset,
    input wire video_sync_t sync,
    input wire layer_pixel_t scr_pxl,           // scroll layer index
    input wire layer_pixel_t obj_pxl,           // sprite layer index
    output pal_addr_t pal_addr,                 // palette port B address
    input wire pal_byte_t pal_data,             // port B data, one clk behind the address
    output colour_t red,
    output colour_t green,
    output colour_t blue
);

    layer_pixel_t pick;                         // index that wins the priority test
    layer_pixel_t idx;                          // index being fetched this pixel period
    pal_byte_t low_byte;                        // first half of the fetched colour
    logic half;                                 // 0 addresses the low byte, 1 the high byte
    logic half_d;                               // half as seen by the data coming back
    logic blank_lat;                            // blank state of the pixel in idx

    // sprite pixel wins unless its low nibble marks it as see-through
    assign pick = (obj_pxl[3:0] != TRANSPARENT_NIBBLE) ? obj_pxl : scr_pxl;

    assign pal_addr = {half, idx};              // low byte at i, high byte at i + 512

    always_ff @(posedge clk) begin
        if (sync.pxl_cen) begin
            idx <= pick;                        // held for the whole fetch
        end
        if (!half_d) begin
            low_byte <= pal_data;               // second clk after pxl_cen
        end
    end

    // the fetch runs in the clk cycles between two pxl_cen pulses:
    // low byte addressed in the first one, high byte from the second one on
    always_ff @(posedge clk) begin
        if (reset) begin
            half <= 1'b1;                       // idle on the high byte
            half_d <= 1'b1;
            blank_lat <= 1'b1;                  // nothing fetched yet, so the first pixel is black
            red <= '0;
            green <= '0;
            blue <= '0;
        end else begin
            half <= !sync.pxl_cen;              // one low byte cycle after each pxl_cen
            half_d <= half;
            if (sync.pxl_cen) begin
                blank_lat <= sync.hblank || sync.vblank;
                // pal_data holds the high byte of idx by now
                if (blank_lat) begin
                    {red, green, blue} <= '0;
                end else begin
                    {red, green, blue} <= {pal_data[6:0], low_byte};
                end
            end
        end
    end

endmodule

`default_nettype wire

/* design/video_colour_top.sv */
// top level of the colour output stage
// raster timing, colour mixer, palette RAM and its APB slave
`timescale 1ns/1ps
`default_nettype none

module video_colour_top
    import video_pkg::*;
(
    input wire logic clk,
    input wire logic reset,
    input wire logic psel,                      // CPU palette access over APB
    input wire logic penable,
    input wire logic pwrite,
    input wire pal_addr_t paddr,
    input wire pal_byte_t pwdata,
    output wire pal_byte_t prdata,
    output wire logic pready,
    input wire layer_pixel_t scr_pxl,           // layer pixels from the tile and sprite engines
    input wire layer_pixel_t obj_pxl,
    output wire colour_t red,
    output wire colour_t green,
    output wire colour_t blue,
    output wire logic pxl_cen,                  // raster timing seen by the outside
    output wire logic hblank,
    output wire logic vblank,
    output wire hcount_t hcount,
    output wire vcount_t vcount
);

    video_sync_t sync;
    pal_addr_t a_addr;                          // APB slave to port A
    logic a_we;
    pal_byte_t a_wdata;
    pal_byte_t a_rdata;
    pal_addr_t b_addr;                          // mixer to port B
    pal_byte_t b_rdata;

    assign pxl_cen = sync.pxl_cen;
    assign hblank = sync.hblank;
    assign vblank = sync.vblank;
    assign hcount = sync.hcount;
    assign vcount = sync.vcount;

    raster_timing raster_timing_inst (.clk(clk), .reset(reset), .sync(sync));

    colour_mixer colour_mixer_inst (
        .clk(clk), .reset(reset), .sync(sync), .scr_pxl(scr_pxl), .obj_pxl(obj_pxl),
        .pal_addr(b_addr), .pal_data(b_rdata), .red(red), .green(green), .blue(blue)
    );

    palette_ram palette_ram_inst (
        .clk(clk), .a_addr(a_addr), .a_we(a_we), .a_wdata(a_wdata), .a_rdata(a_rdata),
        .b_addr(b_addr), .b_rdata(b_rdata)
    );

    palette_apb palette_apb_inst (
        .clk(clk), .reset(reset), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .ram_addr(a_addr), .ram_we(a_we), .ram_wdata(a_wdata), .ram_rdata(a_rdata)
    );

endmodule

`default_nettype wire

/* verif/video_colour_properties.sv */
// bound assertions for the colour output stage
// APB ready timing, black output after blanking and the pixel enable pulse
`timescale 1ns/1ps
`default_nettype none

module video_colour_properties
    import video_pkg::*;
(
    input wire logic clk,
    input wire logic reset,
    input wire logic psel,
    input wire logic penable,
    input wire logic pwrite,
    input wire logic pready,
    input wire logic pxl_cen,
    input wire logic hblank,
    input wire logic vblank,
    input wire colour_t red,
    input wire colour_t green,
    input wire colour_t blue
);

    int setup_fails = 0;                        // one failure count per assertion
    int read_fails = 0;
    int blank_fails = 0;
    int cen_fails = 0;

    // a setup cycle never completes a transfer
    assert property (@(posedge clk) disable iff (reset) (psel && !penable) |-> !pready)
        else begin
            $error("pready high during an APB setup cycle");
            setup_fails++;
        end

    // a read waits one access cycle, so pready comes up two cycles after setup
    assert property (@(posedge clk) disable iff (reset)
        ($past(psel && !penable && !pwrite, 2) && $past(psel && penable))
        |-> (pready && !$past(pready)))
        else begin
            $error("read pready did not rise two cycles after setup");
            read_fails++;
        end

    // the colour of a pixel latched in blanking shows one pixel period plus one clk later
    assert property (@(posedge clk) disable iff (reset)
        $past(pxl_cen && (hblank || vblank), CLK_PER_PIXEL + 1) |-> ({red, green, blue} == '0))
        else begin
            $error("colour output not black for a pixel latched during blanking");
            blank_fails++;
        end

    assert property (@(posedge clk) disable iff (reset) pxl_cen |=> !pxl_cen)
        else begin
            $error("pxl_cen high on two clk cycles in a row");
            cen_fails++;
        end

endmodule

bind video_colour_top video_colour_properties video_colour_properties_inst (
    .clk(clk), .reset(reset), .psel(psel), .penable(penable), .pwrite(pwrite),
    .pready(pready), .pxl_cen(pxl_cen), .hblank(hblank), .vblank(vblank),
    .red(red), .green(green), .blue(blue)
);

`default_nettype wire

/* verif/video_colour_tb.sv */
// testbench for the colour output stage
// APB palette tasks, random palette mirror, pixel tasks and directed tests
`timescale 1ns/1ps
`default_nettype none

module video_colour_tb
    import video_pkg::*;
();

    localparam int FRAME_CLKS = H_TOTAL * V_TOTAL * CLK_PER_PIXEL;  // clk cycles per frame
    localparam int APB_TIMEOUT = 16;            // access cycles allowed before pready
    localparam int ANY_PIXEL = 0;               // kinds of pixel enable cycle to wait for
    localparam int ACTIVE_PIXEL = 1;
    localparam int HBLANK_PIXEL = 2;
    localparam int VBLANK_PIXEL = 3;

    logic clk;
    logic reset;
    logic psel;
    logic penable;
    logic pwrite;
    pal_addr_t paddr;
    pal_byte_t pwdata;
    pal_byte_t prdata;
    logic pready;
    layer_pixel_t scr_pxl;
    layer_pixel_t obj_pxl;
    colour_t red;
    colour_t green;
    colour_t blue;
    logic pxl_cen;
    logic hblank;
    logic vblank;
    hcount_t hcount;
    vcount_t vcount;

    pal_byte_t mirror [0:(1 << PAL_AW) - 1];    // what the palette should hold
    logic [31:0] lcg_state;
    int clk_count;                              // rising edges since reset was released

    video_colour_top video_colour_top_inst (
        .clk(clk), .reset(reset), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .scr_pxl(scr_pxl), .obj_pxl(obj_pxl), .red(red), .green(green), .blue(blue),
        .pxl_cen(pxl_cen), .hblank(hblank), .vblank(vblank), .hcount(hcount), .vcount(vcount)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10;
            clk = ~clk;                         // 20 ns period
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // colour of an index by the palette format, low byte at i and high byte at i + 512
    function automatic logic [14:0] palette_rgb(input layer_pixel_t idx);
        pal_byte_t lo;
        pal_byte_t hi;
        lo = mirror[{1'b0, idx}];
        hi = mirror[{1'b1, idx}];
        return {hi[6:2], hi[1:0], lo[7:5], lo[4:0]};  // red, green, blue
    endfunction

    function automatic logic pixel_kind_matches(input int kind);
        case (kind)
            ACTIVE_PIXEL: return !hblank && !vblank;
            HBLANK_PIXEL: return hblank && !vblank;
            VBLANK_PIXEL: return vblank;
            default: return 1'b1;
        endcase
    endfunction

    function automatic int assertion_failures();
        return video_colour_top_inst.video_colour_properties_inst.setup_fails
            + video_colour_top_inst.video_colour_properties_inst.read_fails
            + video_colour_top_inst.video_colour_properties_inst.blank_fails
            + video_colour_top_inst.video_colour_properties_inst.cen_fails;
    endfunction

    task automatic fail_run();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            fail_run();
        end
    endtask

    task automatic check_rgb(input logic [14:0] expected);
        check_value("red", 32'(red), 32'(expected[14:10]));
        check_value("green", 32'(green), 32'(expected[9:5]));
        check_value("blue", 32'(blue), 32'(expected[4:0]));
    endtask

    // beam state after the n-th clk since reset, counted in finished pixel periods
    task automatic check_raster(input int n);
        int pixels;
        int column;
        int row;
        pixels = (n - 1) / CLK_PER_PIXEL;       // the beam moves on the clk after pxl_cen
        column = pixels % H_TOTAL;
        row = (pixels / H_TOTAL) % V_TOTAL;
        check_value("pxl_cen", 32'(pxl_cen), 32'(n % CLK_PER_PIXEL == 0));
        check_value("hcount", 32'(hcount), 32'(column));
        check_value("vcount", 32'(vcount), 32'(row));
        check_value("hblank", 32'(hblank), 32'(column >= H_ACTIVE));
        check_value("vblank", 32'(vblank), 32'(row >= V_ACTIVE));
    endtask

    // every task starts and ends 2 ns after a rising edge
    task automatic step_clk();
        @(posedge clk);
        #2;
    endtask

    task automatic wait_ready(output int waits);
        waits = 0;
        while (!pready) begin
            if (waits == APB_TIMEOUT) begin
                $display("pready did not rise within %0d access cycles", APB_TIMEOUT);
                fail_run();
            end else begin
                waits++;
                step_clk();
            end
        end
    endtask

    task automatic end_transfer();
        step_clk();                             // transfer completes on this edge
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic apb_write(input pal_addr_t addr, input pal_byte_t data);
        int waits;
        psel = 1'b1;                            // setup cycle
        penable = 1'b0;
        pwrite = 1'b1;
        paddr = addr;
        pwdata = data;
        step_clk();
        penable = 1'b1;
        wait_ready(waits);
        check_value("write wait states", 32'(waits), 0);
        end_transfer();
    endtask

    task automatic apb_read(input pal_addr_t addr, output pal_byte_t data);
        int waits;
        psel = 1'b1;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = addr;
        step_clk();
        penable = 1'b1;
        wait_ready(waits);
        check_value("read wait states", 32'(waits), 1);  // exactly one wait state
        data = prdata;
        end_transfer();
    endtask

    task automatic wait_pixel(input int kind);
        int n;
        n = 0;
        step_clk();
        while (!(pxl_cen && pixel_kind_matches(kind))) begin
            if (n == 2 * FRAME_CLKS) begin
                $display("no pixel enable of kind %0d within two frames", kind);
                fail_run();
            end else begin
                n++;
                step_clk();
            end
        end
    endtask

    // present one pixel at a pxl_cen cycle, its colour shows one clk after the next one
    task automatic show_pixel(input int kind, input layer_pixel_t scr, input layer_pixel_t obj,
                              input logic [14:0] expected);
        wait_pixel(kind);
        scr_pxl = scr;
        obj_pxl = obj;
        wait_pixel(ANY_PIXEL);
        step_clk();
        check_rgb(expected);
    endtask

    task automatic test_reset_state();
        for (int i = 0; i <= CLK_PER_PIXEL; i++) begin
            check_value("pready", 32'(pready), 0);
            check_rgb(15'd0);                   // first pixel after reset is black
            step_clk();
        end
    endtask

    task automatic test_palette_access();
        logic [31:0] r;
        pal_addr_t addr;
        pal_byte_t data;
        for (int a = 0; a < (1 << PAL_AW); a++) begin
            r = lcg_next();
            mirror[a] = r[23:16];
            apb_write(pal_addr_t'(a), r[23:16]);
        end
        for (int i = 0; i < 64; i++) begin
            r = lcg_next();
            addr = r[25:16];
            apb_read(addr, data);
            check_value("prdata", 32'(data), 32'(mirror[addr]));
        end
    endtask

    task automatic test_scroll_colour();
        logic [31:0] r;
        for (int i = 0; i < 16; i++) begin
            r = lcg_next();
            show_pixel(ACTIVE_PIXEL, r[24:16], {r[31:27], 4'hf}, palette_rgb(r[24:16]));
        end
    endtask

    task automatic test_sprite_priority();
        logic [31:0] r;
        layer_pixel_t obj;
        layer_pixel_t winner;
        for (int i = 0; i < 24; i++) begin
            r = lcg_next();
            obj = r[8:0];
            if (i % 4 == 3) begin
                obj[3:0] = 4'hf;                // every fourth sprite pixel is see-through
            end else if (obj[3:0] == 4'hf) begin
                obj[3:0] = 4'h7;
            end
            winner = (i % 4 == 3) ? r[24:16] : obj;  // the scroll pixel shows through
            show_pixel(ACTIVE_PIXEL, r[24:16], obj, palette_rgb(winner));
        end
    endtask

    task automatic test_blanking();
        logic [31:0] r;
        for (int i = 0; i < 8; i++) begin
            r = lcg_next();
            show_pixel((i % 2 == 0) ? HBLANK_PIXEL : VBLANK_PIXEL, r[24:16], r[8:0], 15'd0);
        end
    endtask

    task automatic test_live_update();
        logic [31:0] r;
        layer_pixel_t idx;
        r = lcg_next();
        idx = r[24:16];
        show_pixel(ACTIVE_PIXEL, idx, 9'h00f, palette_rgb(idx));
        r = lcg_next();
        mirror[{1'b0, idx}] = mirror[{1'b0, idx}] ^ (r[23:16] | 8'h01);  // low byte must change
        mirror[{1'b1, idx}] = r[31:24];
        apb_write({1'b0, idx}, mirror[{1'b0, idx}]);
        apb_write({1'b1, idx}, mirror[{1'b1, idx}]);
        for (int i = 0; i < 4; i++) begin
            show_pixel(ACTIVE_PIXEL, idx, 9'h00f, palette_rgb(idx));
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            clk_count <= 0;
        end else begin
            clk_count <= clk_count + 1;
        end
    end

    always @(negedge clk) begin
        if (!reset && assertion_failures() != 0) begin
            $display("a bound assertion failed");
            fail_run();
        end else if (clk_count > 0) begin
            check_raster(clk_count);            // timing outputs settle well before this edge
        end
    end

    initial begin
        reset = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        scr_pxl = '0;
        obj_pxl = '0;
        lcg_state = 32'h57f09902;
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;
        test_reset_state();
        test_palette_access();
        test_scroll_colour();
        test_sprite_priority();
        test_blanking();
        test_live_update();
        if (assertion_failures() != 0) begin
            $display("bound assertions reported %0d failures", assertion_failures());
            fail_run();
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* video_colour_top.f */
design/video_pkg.sv
design/raster_timing.sv
design/palette_ram.sv
design/palette_apb.sv
design/colour_mixer.sv
design/video_colour_top.sv
verif/video_colour_properties.sv
verif/video_colour_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the colour output stage testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module video_colour_tb -f video_colour_top.f

# the error limit lets the testbench see assertion failures and end the run itself
result=$(./obj_dir/Vvideo_colour_tb +verilator+error+limit+100 || true)
echo "$result"
echo "$result" | grep -qx "Simulation passed"
